/* source/tile_cfg.svh */
// Tile configuration macros
// Bus widths, memory depths, address windows and the bus master count
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

`define TILE_DW          32    // Data word
`define TILE_AW          32    // Byte address
`define TILE_SELW        4     // One select per byte lane

`define TILE_LMEM_WORDS  256   // Local SRAM depth
`define TILE_ROM_WORDS   16    // Boot image depth

`define TILE_NR_MASTERS  2     // Instruction and data port of the core

// Top address nibbles of the decoded windows
`define TILE_ROM_NIBBLE  4'hF
`define TILE_NA_NIBBLE   4'hE  // Old network adapter window, answers with err

`endif

/* source/tile_pkg.sv */
// Shared tile types: bus address, data and select words,
// the decode target and the boot image contents
`default_nettype none
`include "tile_cfg.svh"

package tile_pkg;

   typedef logic [`TILE_AW-1:0]   addr_t;
   typedef logic [`TILE_DW-1:0]   data_t;
   typedef logic [`TILE_SELW-1:0] sel_t;

   // Address decode result
   typedef enum logic [1:0] {
      TGT_SRAM,
      TGT_ROM,
      TGT_NONE   // Unmapped, answered by the bus itself
   } target_e;

   typedef data_t boot_image_t [`TILE_ROM_WORDS];

   function automatic boot_image_t make_boot_image();
      boot_image_t img;
      for (int k = 0; k < `TILE_ROM_WORDS; k++) begin
         img[k] = data_t'(32'hB007_0000 + k * 32'h0101);   // Recognisable pattern
      end
      return img;
   endfunction

   localparam boot_image_t boot_image = make_boot_image();

endpackage

`default_nettype wire

/* source/wb_if.sv */
// Wishbone classic single-cycle interface
// Master and slave views, no burst or retry signals
`timescale 1ns/1ns
`default_nettype none

interface wb_if;

   logic            cyc;
   logic            stb;
   logic            we;
   tile_pkg::addr_t adr;
   tile_pkg::data_t dat_w;    // Master to slave
   tile_pkg::sel_t  sel;
   tile_pkg::data_t dat_r;    // Slave to master
   logic            ack;
   logic            err;

   modport master (
      output cyc,
      output stb,
      output we,
      output adr,
      output dat_w,
      output sel,
      input  dat_r,
      input  ack,
      input  err
   );

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  adr,
      input  dat_w,
      input  sel,
      output dat_r,
      output ack,
      output err
   );

endinterface

`default_nettype wire

/* source/tile_bus.sv */
// Local Wishbone interconnect of the tile
// Round-robin master grant, address decode to SRAM or boot ROM,
// and a one-cycle error responder for unmapped addresses
`timescale 1ns/1ns
`default_nettype none
`include "tile_cfg.svh"

module tile_bus (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  masters [`TILE_NR_MASTERS],
   wb_if.master sram_port,
   wb_if.master rom_port
);

   localparam int NR   = `TILE_NR_MASTERS;
   localparam int IDXW = (NR > 1) ? $clog2(NR) : 1;

   logic [NR-1:0]      m_cyc;
   logic [NR-1:0]      m_stb;
   logic [NR-1:0]      m_we;
   tile_pkg::addr_t    m_adr [NR];
   tile_pkg::data_t    m_dat [NR];
   tile_pkg::sel_t     m_sel [NR];

   logic [NR-1:0]      gnt_q;      // One-hot, zero while idle
   logic [IDXW-1:0]    last_q;     // Master served last
   logic [NR-1:0]      pick;
   logic [IDXW-1:0]    pick_idx;
   logic               err_q;

   logic               sel_cyc;
   logic               sel_stb;
   logic               sel_we;
   tile_pkg::addr_t    sel_adr;
   tile_pkg::data_t    sel_dat;
   tile_pkg::sel_t     sel_sel;
   tile_pkg::target_e  tgt;

   logic               rsp_ack;
   logic               rsp_err;
   tile_pkg::data_t    rsp_dat;

   for (genvar i = 0; i < NR; i++) begin : g_master
      assign m_cyc[i] = masters[i].cyc;
      assign m_stb[i] = masters[i].stb;
      assign m_we[i]  = masters[i].we;
      assign m_adr[i] = masters[i].adr;
      assign m_dat[i] = masters[i].dat_w;
      assign m_sel[i] = masters[i].sel;

      assign masters[i].ack   = gnt_q[i] && rsp_ack;   // Only the owner sees the response
      assign masters[i].err   = gnt_q[i] && rsp_err;
      assign masters[i].dat_r = gnt_q[i] ? rsp_dat : '0;
   end

   // Search upward from the master after the one served last
   always_comb begin
      int cand;
      pick     = '0;
      pick_idx = last_q;
      for (int k = 1; k <= NR; k++) begin
         cand = (int'(last_q) + k) % NR;
         if (pick == '0 && m_cyc[cand] && m_stb[cand]) begin
            pick[cand] = 1'b1;
            pick_idx   = IDXW'(cand);
         end
      end
   end

   always_comb begin
      sel_cyc = 1'b0;
      sel_stb = 1'b0;
      sel_we  = 1'b0;
      sel_adr = '0;
      sel_dat = '0;
      sel_sel = '0;
      for (int i = 0; i < NR; i++) begin
         if (gnt_q[i]) begin
            sel_cyc = m_cyc[i];
            sel_stb = m_stb[i];
            sel_we  = m_we[i];
            sel_adr = m_adr[i];
            sel_dat = m_dat[i];
            sel_sel = m_sel[i];
         end
      end
   end

   // Bit 31 low is local memory, the top nibble F is the ROM
   always_comb begin
      tgt = tile_pkg::TGT_NONE;
      if (!sel_adr[`TILE_AW-1]) begin
         tgt = tile_pkg::TGT_SRAM;
      end else if (sel_adr[`TILE_AW-1 -: 4] == `TILE_ROM_NIBBLE) begin
         tgt = tile_pkg::TGT_ROM;
      end
   end

   assign sram_port.cyc   = sel_cyc && (tgt == tile_pkg::TGT_SRAM);
   assign sram_port.stb   = sel_stb && (tgt == tile_pkg::TGT_SRAM);
   assign sram_port.we    = sel_we;
   assign sram_port.adr   = sel_adr;
   assign sram_port.dat_w = sel_dat;
   assign sram_port.sel   = sel_sel;

   assign rom_port.cyc    = sel_cyc && (tgt == tile_pkg::TGT_ROM);
   assign rom_port.stb    = sel_stb && (tgt == tile_pkg::TGT_ROM);
   assign rom_port.we     = sel_we;
   assign rom_port.adr    = sel_adr;
   assign rom_port.dat_w  = sel_dat;
   assign rom_port.sel    = sel_sel;

   always_comb begin
      unique case (tgt)
         tile_pkg::TGT_SRAM: begin
            rsp_ack = sram_port.ack;
            rsp_err = sram_port.err;
            rsp_dat = sram_port.dat_r;
         end
         tile_pkg::TGT_ROM: begin
            rsp_ack = rom_port.ack;
            rsp_err = rom_port.err;
            rsp_dat = rom_port.dat_r;
         end
         default: begin
            rsp_ack = 1'b0;
            rsp_err = err_q;                   // Own error responder
            rsp_dat = '0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         gnt_q  <= '0;
         last_q <= IDXW'(NR - 1);              // Master 0 goes first
         err_q  <= 1'b0;
      end else begin
         err_q <= sel_cyc && sel_stb && (tgt == tile_pkg::TGT_NONE) && !err_q;
         if (gnt_q == '0) begin
            gnt_q <= pick;
            if (pick != '0) begin
               last_q <= pick_idx;
            end
         end else if (rsp_ack || rsp_err) begin
            gnt_q <= '0;                       // Release on end of transfer
         end
      end
   end

endmodule

`default_nettype wire

/* source/mem_access_mux.sv */
// Memory access adapter in front of the local SRAM
// Shares the memory between the bus slave port and the debug port,
// the debug port wins when both ask on the same idle cycle
`timescale 1ns/1ns
`default_nettype none

module mem_access_mux (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  bus_port,
   wb_if.slave  dbg_port,
   wb_if.master mem_port
);

   logic own_bus_q;
   logic own_dbg_q;
   logic bus_req;
   logic dbg_req;
   logic done;

   assign bus_req = bus_port.cyc && bus_port.stb;
   assign dbg_req = dbg_port.cyc && dbg_port.stb;
   assign done    = mem_port.ack || mem_port.err;

   // Owner is locked until the memory answers
   always_ff @(posedge clk) begin
      if (rst_i) begin
         own_bus_q <= 1'b0;
         own_dbg_q <= 1'b0;
      end else if (!own_bus_q && !own_dbg_q) begin
         own_dbg_q <= dbg_req;                 // Debug has priority
         own_bus_q <= bus_req && !dbg_req;
      end else if (done) begin
         own_bus_q <= 1'b0;
         own_dbg_q <= 1'b0;
      end
   end

   assign mem_port.cyc   = (own_dbg_q && dbg_port.cyc) || (own_bus_q && bus_port.cyc);
   assign mem_port.stb   = (own_dbg_q && dbg_port.stb) || (own_bus_q && bus_port.stb);
   assign mem_port.we    = own_dbg_q ? dbg_port.we    : bus_port.we;
   assign mem_port.adr   = own_dbg_q ? dbg_port.adr   : bus_port.adr;
   assign mem_port.dat_w = own_dbg_q ? dbg_port.dat_w : bus_port.dat_w;
   assign mem_port.sel   = own_dbg_q ? dbg_port.sel   : bus_port.sel;

   // The waiting port sees nothing
   assign dbg_port.ack   = own_dbg_q && mem_port.ack;
   assign dbg_port.err   = own_dbg_q && mem_port.err;
   assign dbg_port.dat_r = own_dbg_q ? mem_port.dat_r : '0;

   assign bus_port.ack   = own_bus_q && mem_port.ack;
   assign bus_port.err   = own_bus_q && mem_port.err;
   assign bus_port.dat_r = own_bus_q ? mem_port.dat_r : '0;

endmodule

`default_nettype wire

/* source/local_sram.sv */
// Single-port local SRAM with byte-lane writes
// Registered read data and a one-cycle registered ack
`timescale 1ns/1ns
`default_nettype none
`include "tile_cfg.svh"

module local_sram (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  bus
);

   localparam int IW = $clog2(`TILE_LMEM_WORDS);

   tile_pkg::data_t mem [`TILE_LMEM_WORDS];
   tile_pkg::data_t rd_q;
   logic            ack_q;
   logic            req;
   logic [IW-1:0]   word;

   assign req  = bus.cyc && bus.stb && !ack_q;   // No ack two cycles in a row
   assign word = bus.adr[IW+1:2];                // Word index

   always_ff @(posedge clk) begin
      if (req) begin
         if (bus.we) begin
            for (int b = 0; b < `TILE_SELW; b++) begin
               if (bus.sel[b]) begin
                  mem[word][8*b +: 8] <= bus.dat_w[8*b +: 8];
               end
            end
         end
         rd_q <= mem[word];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;
      end
   end

   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;     // Memory never faults
   assign bus.dat_r = rd_q;

endmodule

`default_nettype wire

/* source/boot_rom.sv */
// Read-only boot image behind a Wishbone slave
// Registered one-cycle ack, writes are answered with err
`timescale 1ns/1ns
`default_nettype none
`include "tile_cfg.svh"

module boot_rom (
   input  logic clk,
   input  logic rst_i,
   wb_if.slave  bus
);

   localparam int IW = $clog2(`TILE_ROM_WORDS);

   tile_pkg::data_t dat_q;
   logic            ack_q;
   logic            err_q;
   logic            req;

   assign req = bus.cyc && bus.stb && !ack_q && !err_q;

   always_ff @(posedge clk) begin
      if (req) begin
         dat_q <= tile_pkg::boot_image[bus.adr[IW+1:2]];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req && !bus.we;
         err_q <= req && bus.we;   // Image is read-only
      end
   end

   assign bus.ack   = ack_q;
   assign bus.err   = err_q;
   assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

/* source/compute_tile.sv */
// Compute tile bus and memory subsystem
// Two core bus masters and a debug memory port on plain ports,
// interconnect, SRAM access adapter, local SRAM and boot ROM
`timescale 1ns/1ns
`default_nettype none
`include "tile_cfg.svh"

module compute_tile (
   input  logic            clk,
   input  logic            rst_i,
   // Instruction port
   input  logic            m0_cyc_i, m0_stb_i, m0_we_i,
   input  tile_pkg::addr_t m0_adr_i,
   input  tile_pkg::data_t m0_dat_i,
   input  tile_pkg::sel_t  m0_sel_i,
   output tile_pkg::data_t m0_dat_o,
   output logic            m0_ack_o, m0_err_o,
   // Data port
   input  logic            m1_cyc_i, m1_stb_i, m1_we_i,
   input  tile_pkg::addr_t m1_adr_i,
   input  tile_pkg::data_t m1_dat_i,
   input  tile_pkg::sel_t  m1_sel_i,
   output tile_pkg::data_t m1_dat_o,
   output logic            m1_ack_o, m1_err_o,
   // Debug memory access
   input  logic            dbg_cyc_i, dbg_stb_i, dbg_we_i,
   input  tile_pkg::addr_t dbg_adr_i,
   input  tile_pkg::data_t dbg_dat_i,
   input  tile_pkg::sel_t  dbg_sel_i,
   output tile_pkg::data_t dbg_dat_o,
   output logic            dbg_ack_o, dbg_err_o
);

   wb_if m_bus [`TILE_NR_MASTERS] ();   // Core masters into the bus
   wb_if sram_bus ();                   // Bus slave side of the adapter
   wb_if rom_bus ();
   wb_if dbg_bus ();
   wb_if mem_bus ();                    // Adapter to SRAM

   assign m_bus[0].cyc   = m0_cyc_i;
   assign m_bus[0].stb   = m0_stb_i;
   assign m_bus[0].we    = m0_we_i;
   assign m_bus[0].adr   = m0_adr_i;
   assign m_bus[0].dat_w = m0_dat_i;
   assign m_bus[0].sel   = m0_sel_i;
   assign m0_dat_o       = m_bus[0].dat_r;
   assign m0_ack_o       = m_bus[0].ack;
   assign m0_err_o       = m_bus[0].err;

   assign m_bus[1].cyc   = m1_cyc_i;
   assign m_bus[1].stb   = m1_stb_i;
   assign m_bus[1].we    = m1_we_i;
   assign m_bus[1].adr   = m1_adr_i;
   assign m_bus[1].dat_w = m1_dat_i;
   assign m_bus[1].sel   = m1_sel_i;
   assign m1_dat_o       = m_bus[1].dat_r;
   assign m1_ack_o       = m_bus[1].ack;
   assign m1_err_o       = m_bus[1].err;

   assign dbg_bus.cyc    = dbg_cyc_i;
   assign dbg_bus.stb    = dbg_stb_i;
   assign dbg_bus.we     = dbg_we_i;
   assign dbg_bus.adr    = dbg_adr_i;
   assign dbg_bus.dat_w  = dbg_dat_i;
   assign dbg_bus.sel    = dbg_sel_i;
   assign dbg_dat_o      = dbg_bus.dat_r;
   assign dbg_ack_o      = dbg_bus.ack;
   assign dbg_err_o      = dbg_bus.err;

   tile_bus u_bus (
      .clk       (clk),
      .rst_i     (rst_i),
      .masters   (m_bus),
      .sram_port (sram_bus),
      .rom_port  (rom_bus)
   );

   mem_access_mux u_mem_access (
      .clk      (clk),
      .rst_i    (rst_i),
      .bus_port (sram_bus),
      .dbg_port (dbg_bus),
      .mem_port (mem_bus)
   );

   local_sram u_ram (
      .clk   (clk),
      .rst_i (rst_i),
      .bus   (mem_bus)
   );

   boot_rom u_bootrom (
      .clk   (clk),
      .rst_i (rst_i),
      .bus   (rom_bus)
   );

endmodule

`default_nettype wire

/* verification/compute_tile_assertions.sv */
// Wishbone protocol assertions for the tile interconnect
// Bound into tile_bus from the testbench
`timescale 1ns/1ns
`default_nettype none
`include "tile_cfg.svh"

module compute_tile_assertions (
   input logic                        clk,
   input logic                        rst_i,
   input logic [`TILE_NR_MASTERS-1:0] gnt,
   input logic                        ack,
   input logic                        err,
   input logic                        cyc,   // Granted master's request
   input logic                        stb
);

   ack_err_excl: assert property (@(posedge clk) disable iff (rst_i) !(ack && err))
      else $error("ack and err high in the same cycle");

   resp_pending: assert property (@(posedge clk) disable iff (rst_i)
      (ack || err) |-> (cyc && stb && gnt != '0))
      else $error("response without a pending request");

   gnt_onehot: assert property (@(posedge clk) disable iff (rst_i) $onehot0(gnt))
      else $error("more than one master holds the grant");

endmodule

`default_nettype wire

/* verification/tb_compute_tile.sv */
// Testbench for the compute tile bus and memory subsystem
// Replays transfers from the vector file, checks them against an SRAM and ROM
// reference model, runs contention pairs, watchdog and summary
`timescale 1ns/1ns
`default_nettype none
`include "tile_cfg.svh"

module tb_compute_tile;

   typedef struct {
      int              test;
      int              port;    // 0 m0, 1 m1, 2 dbg
      bit              we;
      tile_pkg::addr_t adr;
      tile_pkg::data_t wdat;
      tile_pkg::sel_t  sel;
      int              mode;    // 0 alone, 1 same cycle as next, 2 random offsets
      bit              err;     // Error response expected
      bit              chk;     // Read data compared
      tile_pkg::data_t exp;
   } vec_t;

   logic                clk;
   logic                rst_i;
   logic                cyc [3];
   logic                stb [3];
   logic                we [3];
   tile_pkg::addr_t     adr [3];
   tile_pkg::data_t     wdat [3];
   tile_pkg::sel_t      sel [3];
   wire [`TILE_DW-1:0]  rdat [3];
   wire                 ack [3];
   wire                 err [3];

   vec_t                vecs [$];
   tile_pkg::data_t     sram_model [`TILE_LMEM_WORDS];
   string               pname [3] = '{"m0", "m1", "dbg"};
   integer              seed = 32'hf061_fc65;
   int                  errors = 0;
   int                  checks = 0;
   int                  tests = 0;
   int                  test_errors = 0;
   int                  test_trans = 0;

   compute_tile i_compute_tile (
      .clk       (clk),
      .rst_i     (rst_i),
      .m0_cyc_i  (cyc[0]),
      .m0_stb_i  (stb[0]),
      .m0_we_i   (we[0]),
      .m0_adr_i  (adr[0]),
      .m0_dat_i  (wdat[0]),
      .m0_sel_i  (sel[0]),
      .m0_dat_o  (rdat[0]),
      .m0_ack_o  (ack[0]),
      .m0_err_o  (err[0]),
      .m1_cyc_i  (cyc[1]),
      .m1_stb_i  (stb[1]),
      .m1_we_i   (we[1]),
      .m1_adr_i  (adr[1]),
      .m1_dat_i  (wdat[1]),
      .m1_sel_i  (sel[1]),
      .m1_dat_o  (rdat[1]),
      .m1_ack_o  (ack[1]),
      .m1_err_o  (err[1]),
      .dbg_cyc_i (cyc[2]),
      .dbg_stb_i (stb[2]),
      .dbg_we_i  (we[2]),
      .dbg_adr_i (adr[2]),
      .dbg_dat_i (wdat[2]),
      .dbg_sel_i (sel[2]),
      .dbg_dat_o (rdat[2]),
      .dbg_ack_o (ack[2]),
      .dbg_err_o (err[2])
   );

   bind tile_bus compute_tile_assertions i_bus_assertions (
      .clk   (clk),
      .rst_i (rst_i),
      .gnt   (gnt_q),
      .ack   (rsp_ack),
      .err   (rsp_err),
      .cyc   (sel_cyc),
      .stb   (sel_stb)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         errors++;
         test_errors++;
      end
   endtask

   task automatic load_vectors();
      int    fd;
      int    n;
      string line;
      string port_s;
      string op_s;
      string mode_s;
      string exp_s;
      vec_t  v;
      fd = $fopen("verification/compute_tile_vectors.txt", "r");
      if (fd == 0) begin
         $display("The vector file could not be opened");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %s %s %h %h %h %s %s", v.test, port_s, op_s,
                        v.adr, v.wdat, v.sel, mode_s, exp_s);
            if (n == 8) begin   // Comment lines fail the scan
               v.port = (port_s == "m0") ? 0 : (port_s == "m1") ? 1 : 2;
               v.we   = (op_s == "W");
               v.mode = (mode_s == "same") ? 1 : (mode_s == "rand") ? 2 : 0;
               v.err  = (exp_s == "ERR");
               v.chk  = !v.err && (exp_s != "-");
               v.exp  = '0;
               if (v.chk) begin
                  void'($sscanf(exp_s, "%h", v.exp));
               end
               vecs.push_back(v);
            end
         end
         $fclose(fd);
      end
   endtask

   // Reference model: bit 31 low is SRAM, nibble F is the boot ROM, the rest errs
   function automatic void predict(input vec_t v, output logic e, output tile_pkg::data_t q);
      logic [7:0] idx;
      idx = v.adr[9:2];
      e   = 1'b0;
      q   = '0;
      if (!v.adr[31]) begin
         if (v.we) begin
            for (int b = 0; b < `TILE_SELW; b++) begin
               if (v.sel[b]) begin
                  sram_model[idx][8*b +: 8] = v.wdat[8*b +: 8];
               end
            end
         end else begin
            q = sram_model[idx];
         end
      end else if (v.adr[31:28] == `TILE_ROM_NIBBLE && !v.we) begin
         q = 32'hB007_0000 + 32'(v.adr[5:2]) * 32'h0101;
      end else begin
         e = 1'b1;
      end
   endfunction

   task automatic cross_check(input int i);
      logic            e;
      tile_pkg::data_t q;
      predict(vecs[i], e, q);
      check("vector_err", e, vecs[i].err);
      if (vecs[i].chk) begin
         check("vector_dat", q, vecs[i].exp);
      end
   endtask

   task automatic drive_transfer(input int i, input int off);
      vec_t            v;
      int              p;
      tile_pkg::data_t q;
      logic            e;
      logic            a;
      v = vecs[i];
      p = v.port;
      repeat (off) @(negedge clk);
      @(negedge clk);
      cyc[p]  = 1'b1;
      stb[p]  = 1'b1;
      we[p]   = v.we;
      adr[p]  = v.adr;
      wdat[p] = v.wdat;
      sel[p]  = v.sel;
      @(negedge clk);
      while (!(ack[p] || err[p])) @(negedge clk);
      q = rdat[p];
      e = err[p];
      a = ack[p];
      @(negedge clk);   // Request held through the ack cycle
      cyc[p] = 1'b0;
      stb[p] = 1'b0;
      we[p]  = 1'b0;
      check({pname[p], "_ack_o"}, !v.err, a);
      check({pname[p], "_err_o"}, v.err, e);
      if (v.chk) begin
         check({pname[p], "_dat_o"}, v.exp, q);
      end
      test_trans++;
   endtask

   task automatic watchdog(input int cycles);
      repeat (cycles) @(posedge clk);
      $display("Timeout: a bus transfer never completed within %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
   endtask

   initial begin
      int i;
      int off0;
      int off1;
      rst_i = 1'b1;
      for (int p = 0; p < 3; p++) begin
         cyc[p]  = 1'b0;
         stb[p]  = 1'b0;
         we[p]   = 1'b0;
         adr[p]  = '0;
         wdat[p] = '0;
         sel[p]  = '0;
      end
      load_vectors();
      if (vecs.size() > 0) begin
         fork
            watchdog(vecs.size() * 40);
         join_none
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;
      i = 0;
      while (i < vecs.size()) begin
         if (vecs[i].mode != 0 && i + 1 < vecs.size()) begin
            off0 = 0;
            off1 = 0;
            if (vecs[i].mode == 2) begin
               off0 = $unsigned($random(seed)) % 4;
               off1 = $unsigned($random(seed)) % 4;
            end
            cross_check(i);       // Model order is the service order
            cross_check(i + 1);
            fork
               drive_transfer(i, off0);
               drive_transfer(i + 1, off1);
            join
            i += 2;
         end else begin
            cross_check(i);
            drive_transfer(i, 0);
            i += 1;
         end
         if (i >= vecs.size() || vecs[i].test != vecs[i-1].test) begin
            $display("Test %0d finished: %0d transfers, %0d errors",
                     vecs[i-1].test, test_trans, test_errors);
            tests++;
            test_trans  = 0;
            test_errors = 0;
         end
      end
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0 && vecs.size() > 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/tile_pkg.sv
source/wb_if.sv
source/tile_bus.sv
source/mem_access_mux.sv
source/local_sram.sv
source/boot_rom.sv
source/compute_tile.sv
verification/compute_tile_assertions.sv
verification/tb_compute_tile.sv

/* verification/compute_tile_vectors.txt */
# test port op addr data sel mode expect
# mode: seq alone, same/rand paired with next line; expect: read hex, - write ack, ERR
1 m0  W 00000040 cafef00d f seq  -
1 m1  R 00000040 00000000 f seq  cafef00d
2 m0  W 00000044 11223344 f seq  -
2 m1  W 00000044 aabbccdd 5 seq  -
2 m0  W 00000044 99000000 8 seq  -
2 m1  R 00000044 00000000 f seq  99bb33dd
3 m0  R f0000008 00000000 f seq  b0070202
3 m1  R f000003c 00000000 f seq  b0070f0f
3 m0  W f0000004 12345678 f seq  ERR
4 m1  W e0000040 deadbeef f seq  ERR
4 m0  W 80000040 deadbeef f seq  ERR
4 m1  R d0000000 00000000 f seq  ERR
4 m0  R 00000040 00000000 f seq  cafef00d
5 dbg W 00000080 5a5a5a5a f seq  -
5 m0  R 00000080 00000000 f seq  5a5a5a5a
5 dbg W 00000084 0d0d0d0d f same -
5 m0  W 00000084 0e0e0e0e f same -
5 m0  R 00000084 00000000 f seq  0e0e0e0e
6 m0  R 00000044 00000000 f rand 99bb33dd
6 m1  R f0000000 00000000 f rand b0070000
6 m0  R f0000014 00000000 f rand b0070505
6 m1  R 00000080 00000000 f rand 5a5a5a5a
6 m0  W 00000048 01020304 f rand -
6 m1  R f0000028 00000000 f rand b0070a0a
